// ==== verilog/ccc_consts.svh ====
// CCC codes, GET reply lengths and fixed bytes, included by every CCC RTL source
`ifndef CCC_CONSTS_SVH
`define CCC_CONSTS_SVH

// Broadcast CCCs, bit 7 clear
`define CCC_BCAST_RSTDAA     8'h06
`define CCC_BCAST_SETMWL     8'h09
`define CCC_BCAST_SETMRL     8'h0A
`define CCC_BCAST_SETAASA    8'h29

// Direct CCCs, bit 7 set
`define CCC_DIRECT_ENEC      8'h80
`define CCC_DIRECT_DISEC     8'h81
`define CCC_DIRECT_SETDASA   8'h87
`define CCC_DIRECT_SETMWL    8'h89
`define CCC_DIRECT_SETMRL    8'h8A
`define CCC_DIRECT_GETMWL    8'h8B
`define CCC_DIRECT_GETMRL    8'h8C
`define CCC_DIRECT_GETPID    8'h8D
`define CCC_DIRECT_GETBCR    8'h8E
`define CCC_DIRECT_GETDCR    8'h8F
`define CCC_DIRECT_GETSTATUS 8'h90

// Reserved broadcast address, 7 bits
`define CCC_RSVD_ADDR        7'h7E

// Third GETMRL byte, max IBI payload
`define CCC_MRL_IBI_PAD      8'hFF

// Reply byte counts of the direct GETs
`define CCC_LEN_GETBCR       8'd1
`define CCC_LEN_GETDCR       8'd1
`define CCC_LEN_GETSTATUS    8'd2
`define CCC_LEN_GETMWL       8'd2
`define CCC_LEN_GETMRL       8'd3
`define CCC_LEN_GETPID       8'd6

`endif

// ==== verilog/ccc_pkg.sv ====
// Packed struct types shared by the CCC handler RTL and its testbench
package ccc_pkg;

  // Bus monitor detect pulses
  typedef struct packed {
    logic start;
    logic rstart;
    logic stop;
  } bus_evt_t;

  // Bus engine done pulses and received byte
  typedef struct packed {
    logic       rx_done;
    logic       tx_done;
    logic [7:0] rx_data;
  } bus_rx_t;

  // Request levels towards the bus engine
  // Each level holds until the matching done pulse
  typedef struct packed {
    logic       rx_req_bit;
    logic       rx_req_byte;
    logic       tx_req_bit;
    logic       tx_req_byte;
    logic [7:0] tx_value;
  } bus_req_t;

  // Target addresses, dynamic one wins when valid
  typedef struct packed {
    logic [6:0] sta_addr;
    logic       sta_valid;
    logic [6:0] dyn_addr;
    logic       dyn_valid;
  } tgt_addr_t;

  // Register values returned by the direct GETs
  typedef struct packed {
    logic [7:0]  bcr;
    logic [7:0]  dcr;
    logic [15:0] status;
    logic [15:0] mwl;
    logic [15:0] mrl;
    logic [47:0] pid;
  } dev_info_t;

  typedef logic [15:0] len_t;

  // ENEC/DISEC event byte
  typedef struct packed {
    logic [3:0] rsvd_hi;
    logic       hj;
    logic       rsvd_lo;
    logic       crr;
    logic       ibi;
  } event_mask_t;

  // Stream from the frame FSM to the datapath blocks
  typedef struct packed {
    logic [7:0] code;
    logic       strobe;
    logic [7:0] idx;
    logic       rnw;
    logic       is_direct;
    logic       bcast_tbit;
  } ccc_data_t;

endpackage

// ==== verilog/ccc_ctrl_fsm.sv ====
// CCC frame FSM, steps the bus engine through a CCC and feeds the datapath stream
`timescale 1ns/10ps
`include "ccc_consts.svh"

module ccc_ctrl_fsm
  import ccc_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic [7:0] ccc_i,
  input  logic       ccc_valid_i,
  input  bus_evt_t   bus_evt_i,
  input  bus_rx_t    bus_rx_i,
  input  tgt_addr_t  tgt_addr_i,
  input  logic [7:0] tx_byte_i,
  input  logic       tx_last_i,
  output bus_req_t   bus_req_o,
  output ccc_data_t  data_o,
  output logic [7:0] rx_byte_o,
  output logic       done_o,
  output logic       get_status_done_o
);

  typedef enum logic [3:0] {
    st_wait_ccc,
    st_rx_tbit,
    st_rx_byte,
    st_rx_def_tbit,
    st_rx_addr,
    st_tx_addr_ack,
    st_wait_sr,
    st_rx_data,
    st_rx_data_tbit,
    st_tx_data,
    st_tx_data_tbit,
    st_done
  } state_e;

  state_e     state_q;
  state_e     state_d;
  logic [7:0] code_q;
  logic [6:0] addr_q;
  logic       rnw_q;
  logic [7:0] rx_byte_q;
  logic [7:0] idx_q;
  logic       status_pend_q;
  logic       is_direct;
  logic       rx_rsvd;
  logic       rx_ours;
  logic       addr_rsvd_q;
  logic       data_strobe;
  logic       bcast_tbit;

  assign is_direct = code_q[7];

  // Reserved 7E with write bit, ACKed by every target
  assign rx_rsvd     = bus_rx_i.rx_data == {`CCC_RSVD_ADDR, 1'b0};
  assign addr_rsvd_q = (addr_q == `CCC_RSVD_ADDR) && !rnw_q;

  // Address match on the incoming byte
  // Dynamic address first, static as fallback
  always_comb begin
    if (tgt_addr_i.dyn_valid) begin
      rx_ours = bus_rx_i.rx_data[7:1] == tgt_addr_i.dyn_addr;
    end else if (tgt_addr_i.sta_valid) begin
      rx_ours = bus_rx_i.rx_data[7:1] == tgt_addr_i.sta_addr;
    end else begin
      rx_ours = 1'b0;
    end
  end

  // Stream pulses, dropped when a STOP aborts the frame
  assign data_strobe = (state_q == st_rx_data_tbit) && bus_rx_i.rx_done && !bus_evt_i.stop;
  assign bcast_tbit  = (state_q == st_rx_tbit) && bus_rx_i.rx_done && !is_direct &&
                       !bus_evt_i.stop;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      st_wait_ccc: begin
        if (ccc_valid_i) state_d = st_rx_tbit;
      end
      st_rx_tbit: begin
        if (bus_rx_i.rx_done) state_d = is_direct ? st_rx_byte : st_rx_data;
      end
      // Defining bytes until the Sr before the direct address
      st_rx_byte: begin
        if (bus_evt_i.rstart) state_d = st_rx_addr;
        else if (bus_rx_i.rx_done) state_d = st_rx_def_tbit;
      end
      st_rx_def_tbit: begin
        if (bus_rx_i.rx_done) state_d = st_rx_byte;
      end
      // Foreign address is not ACKed, wait for the next Sr
      st_rx_addr: begin
        if (bus_rx_i.rx_done) state_d = (rx_rsvd || rx_ours) ? st_tx_addr_ack : st_wait_sr;
      end
      st_tx_addr_ack: begin
        if (bus_rx_i.tx_done) begin
          if (addr_rsvd_q) state_d = st_done;
          else if (rnw_q) state_d = tx_last_i ? st_wait_sr : st_tx_data;
          else state_d = st_rx_data;
        end
      end
      st_wait_sr: begin
        if (bus_evt_i.rstart) state_d = st_rx_addr;
      end
      st_rx_data: begin
        if (bus_evt_i.rstart) state_d = st_rx_addr;
        else if (bus_rx_i.rx_done) state_d = st_rx_data_tbit;
      end
      st_rx_data_tbit: begin
        if (bus_rx_i.rx_done) state_d = st_rx_data;
      end
      st_tx_data: begin
        if (bus_rx_i.tx_done) state_d = st_tx_data_tbit;
      end
      st_tx_data_tbit: begin
        if (bus_rx_i.tx_done) state_d = tx_last_i ? st_wait_sr : st_tx_data;
      end
      // A new handoff may arrive right with done
      st_done: begin
        state_d = ccc_valid_i ? st_rx_tbit : st_wait_ccc;
      end
      default: begin
        state_d = st_wait_ccc;
      end
    endcase
  end

  // STOP ends the frame from any state
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= st_wait_ccc;
    end else if (bus_evt_i.stop) begin
      state_q <= st_done;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      code_q <= '0;
      addr_q <= '0;
      rnw_q  <= 1'b0;
      idx_q  <= '0;
    end else begin
      if (ccc_valid_i) code_q <= ccc_i;
      // Read bit cleared until the next address is in
      if (ccc_valid_i || bus_evt_i.rstart) begin
        rnw_q <= 1'b0;
      end else if (state_q == st_rx_addr && bus_rx_i.rx_done) begin
        addr_q <= bus_rx_i.rx_data[7:1];
        rnw_q  <= bus_rx_i.rx_data[0];
      end
      if (ccc_valid_i) idx_q <= '0;
      else if (data_strobe) idx_q <= idx_q + 8'd1;
    end
  end

  // Data byte held through its T-bit
  always_ff @(posedge clk_i) begin
    if (state_q == st_rx_data && bus_rx_i.rx_done) rx_byte_q <= bus_rx_i.rx_data;
  end

  // GETSTATUS completion one cycle after done
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      status_pend_q     <= 1'b0;
      get_status_done_o <= 1'b0;
    end else begin
      if (done_o) status_pend_q <= 1'b0;
      else if (ccc_valid_i && ccc_i == `CCC_DIRECT_GETSTATUS) status_pend_q <= 1'b1;
      get_status_done_o <= status_pend_q && done_o;
    end
  end

  always_comb begin
    bus_req_o = '0;
    unique case (state_q)
      st_rx_tbit, st_rx_def_tbit, st_rx_data_tbit: begin
        bus_req_o.rx_req_bit = 1'b1;
      end
      st_rx_byte, st_rx_addr, st_rx_data: begin
        bus_req_o.rx_req_byte = 1'b1;
      end
      // ACK drives SDA low
      st_tx_addr_ack: begin
        bus_req_o.tx_req_bit = 1'b1;
      end
      st_tx_data: begin
        bus_req_o.tx_req_byte = 1'b1;
        bus_req_o.tx_value    = tx_byte_i;
      end
      // T-bit high while more bytes follow
      st_tx_data_tbit: begin
        bus_req_o.tx_req_bit = 1'b1;
        bus_req_o.tx_value   = {7'h00, ~tx_last_i};
      end
      default: begin
      end
    endcase
  end

  assign data_o.code       = code_q;
  assign data_o.strobe     = data_strobe;
  assign data_o.idx        = idx_q;
  assign data_o.rnw        = rnw_q;
  assign data_o.is_direct  = is_direct;
  assign data_o.bcast_tbit = bcast_tbit;
  assign rx_byte_o         = rx_byte_q;
  assign done_o            = state_q == st_done;

endmodule

// ==== verilog/ccc_get_responder.sv ====
// Direct GET reply source, picks each reply byte and counts the bytes left to send
`timescale 1ns/10ps
`include "ccc_consts.svh"

module ccc_get_responder
  import ccc_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  ccc_data_t  data_i,
  input  bus_rx_t    bus_rx_i,
  input  dev_info_t  dev_info_i,
  output logic [7:0] tx_byte_o,
  output logic       tx_last_o
);

  logic [7:0] len_init;
  logic [7:0] cnt_q;
  logic       in_byte_q;

  // Reply length per code, zero for anything but a GET
  always_comb begin
    unique case (data_i.code)
      `CCC_DIRECT_GETBCR:    len_init = `CCC_LEN_GETBCR;
      `CCC_DIRECT_GETDCR:    len_init = `CCC_LEN_GETDCR;
      `CCC_DIRECT_GETSTATUS: len_init = `CCC_LEN_GETSTATUS;
      `CCC_DIRECT_GETMWL:    len_init = `CCC_LEN_GETMWL;
      `CCC_DIRECT_GETMRL:    len_init = `CCC_LEN_GETMRL;
      `CCC_DIRECT_GETPID:    len_init = `CCC_LEN_GETPID;
      default:               len_init = 8'd0;
    endcase
  end

  // Reloaded until a read address is latched
  // First tx done after that is the ACK, then byte and T-bit alternate
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q     <= '0;
      in_byte_q <= 1'b0;
    end else if (!data_i.rnw) begin
      cnt_q     <= len_init;
      in_byte_q <= 1'b0;
    end else if (bus_rx_i.tx_done) begin
      if (in_byte_q && !tx_last_o) cnt_q <= cnt_q - 8'd1;
      in_byte_q <= !in_byte_q;
    end
  end

  assign tx_last_o = cnt_q == 8'd0;

  // Most significant byte goes out first
  always_comb begin
    tx_byte_o = 8'h00;
    if (!tx_last_o) begin
      unique case (data_i.code)
        `CCC_DIRECT_GETBCR: tx_byte_o = dev_info_i.bcr;
        `CCC_DIRECT_GETDCR: tx_byte_o = dev_info_i.dcr;
        `CCC_DIRECT_GETSTATUS: begin
          tx_byte_o = (cnt_q == 8'd2) ? dev_info_i.status[15:8] : dev_info_i.status[7:0];
        end
        `CCC_DIRECT_GETMWL: begin
          tx_byte_o = (cnt_q == 8'd2) ? dev_info_i.mwl[15:8] : dev_info_i.mwl[7:0];
        end
        // Pad byte last
        `CCC_DIRECT_GETMRL: begin
          if (cnt_q == 8'd3) tx_byte_o = dev_info_i.mrl[15:8];
          else if (cnt_q == 8'd2) tx_byte_o = dev_info_i.mrl[7:0];
          else tx_byte_o = `CCC_MRL_IBI_PAD;
        end
        `CCC_DIRECT_GETPID: begin
          unique case (cnt_q)
            8'd6:    tx_byte_o = dev_info_i.pid[47:40];
            8'd5:    tx_byte_o = dev_info_i.pid[39:32];
            8'd4:    tx_byte_o = dev_info_i.pid[31:24];
            8'd3:    tx_byte_o = dev_info_i.pid[23:16];
            8'd2:    tx_byte_o = dev_info_i.pid[15:8];
            default: tx_byte_o = dev_info_i.pid[7:0];
          endcase
        end
        default: tx_byte_o = 8'h00;
      endcase
    end
  end

endmodule

// ==== verilog/ccc_set_capture.sv ====
// Generic SET payload register, shifts in strobed bytes for two matching CCC codes
`timescale 1ns/10ps
`include "ccc_consts.svh"

module ccc_set_capture
  import ccc_pkg::*;
#(
  parameter type        payload_t = len_t,
  parameter logic [7:0] CODE_A    = `CCC_BCAST_SETMWL,
  parameter logic [7:0] CODE_B    = `CCC_DIRECT_SETMWL
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  ccc_data_t  data_i,
  input  logic [7:0] byte_i,
  output payload_t   payload_o,
  output logic       set_o
);

  // Byte count follows the payload width
  localparam int unsigned WIDTH  = $bits(payload_t);
  localparam int unsigned NBYTES = WIDTH / 8;

  logic             code_hit;
  logic             byte_hit;
  logic             last_byte;
  logic [WIDTH+7:0] shifted;
  logic [WIDTH-1:0] payload_q;

  assign code_hit  = (data_i.code == CODE_A) || (data_i.code == CODE_B);
  // Extra bytes past the payload are ignored
  assign byte_hit  = code_hit && data_i.strobe && (data_i.idx < 8'(NBYTES));
  assign last_byte = data_i.idx == 8'(NBYTES - 1);
  // Earlier bytes move up, so byte 0 ends as MSB
  assign shifted   = {payload_q, byte_i};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      payload_q <= '0;
      set_o     <= 1'b0;
    end else begin
      if (byte_hit) payload_q <= shifted[WIDTH-1:0];
      set_o <= byte_hit && last_byte;
    end
  end

  assign payload_o = payload_t'(payload_q);

endmodule

// ==== verilog/ccc_addr_setter.sv ====
// Dynamic address updates from SETDASA, SETAASA and RSTDAA
`timescale 1ns/10ps
`include "ccc_consts.svh"

module ccc_addr_setter
  import ccc_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  ccc_data_t  data_i,
  input  logic [7:0] byte_i,
  input  tgt_addr_t  tgt_addr_i,
  output logic [6:0] set_dasa_o,
  output logic       set_dasa_valid_o,
  output logic       rstdaa_o
);

  logic setaasa_hit;
  logic setdasa_hit;
  logic rstdaa_hit;

  // Broadcasts act on the T-bit after the code
  assign setaasa_hit = data_i.bcast_tbit && (data_i.code == `CCC_BCAST_SETAASA);
  assign rstdaa_hit  = data_i.bcast_tbit && (data_i.code == `CCC_BCAST_RSTDAA);
  // SETDASA carries the address in byte 0, bit 0 unused
  assign setdasa_hit = data_i.strobe && (data_i.code == `CCC_DIRECT_SETDASA) &&
                       (data_i.idx == 8'd0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      set_dasa_o       <= '0;
      set_dasa_valid_o <= 1'b0;
      rstdaa_o         <= 1'b0;
    end else begin
      // SETAASA first, static address becomes dynamic
      if (setaasa_hit) begin
        set_dasa_o <= tgt_addr_i.sta_addr;
      end else if (setdasa_hit) begin
        set_dasa_o <= byte_i[7:1];
      end
      set_dasa_valid_o <= setaasa_hit || setdasa_hit;
      rstdaa_o         <= rstdaa_hit;
    end
  end

endmodule

// ==== verilog/ccc_top.sv ====
// CCC handler top level, connects the frame FSM to the GET, SET and address blocks
`timescale 1ns/10ps
`include "ccc_consts.svh"

module ccc_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic [7:0]           ccc_i,
  input  logic                 ccc_valid_i,
  input  ccc_pkg::bus_evt_t    bus_evt_i,
  input  ccc_pkg::bus_rx_t     bus_rx_i,
  input  ccc_pkg::tgt_addr_t   tgt_addr_i,
  input  ccc_pkg::dev_info_t   dev_info_i,
  output ccc_pkg::bus_req_t    bus_req_o,
  output logic                 done_o,
  output logic                 get_status_done_o,
  output ccc_pkg::len_t        mwl_o,
  output logic                 set_mwl_o,
  output ccc_pkg::len_t        mrl_o,
  output logic                 set_mrl_o,
  output ccc_pkg::event_mask_t enec_o,
  output ccc_pkg::event_mask_t disec_o,
  output logic [6:0]           set_dasa_o,
  output logic                 set_dasa_valid_o,
  output logic                 rstdaa_o
);

  ccc_pkg::ccc_data_t   ccc_data;
  logic [7:0]           rx_byte;
  logic [7:0]           tx_byte;
  logic                 tx_last;
  ccc_pkg::event_mask_t enec_raw;
  ccc_pkg::event_mask_t disec_raw;

  ccc_ctrl_fsm u_ctrl_fsm (
    .clk_i,
    .rst_ni,
    .ccc_i,
    .ccc_valid_i,
    .bus_evt_i,
    .bus_rx_i,
    .tgt_addr_i,
    .tx_byte_i         (tx_byte),
    .tx_last_i         (tx_last),
    .bus_req_o,
    .data_o            (ccc_data),
    .rx_byte_o         (rx_byte),
    .done_o,
    .get_status_done_o
  );

  ccc_get_responder u_get_responder (
    .clk_i,
    .rst_ni,
    .data_i     (ccc_data),
    .bus_rx_i,
    .dev_info_i,
    .tx_byte_o  (tx_byte),
    .tx_last_o  (tx_last)
  );

  // MWL, broadcast or direct
  ccc_set_capture #(
    .payload_t (ccc_pkg::len_t),
    .CODE_A    (`CCC_BCAST_SETMWL),
    .CODE_B    (`CCC_DIRECT_SETMWL)
  ) u_set_mwl (
    .clk_i,
    .rst_ni,
    .data_i    (ccc_data),
    .byte_i    (rx_byte),
    .payload_o (mwl_o),
    .set_o     (set_mwl_o)
  );

  // MRL, third byte of SETMRL dropped
  ccc_set_capture #(
    .payload_t (ccc_pkg::len_t),
    .CODE_A    (`CCC_BCAST_SETMRL),
    .CODE_B    (`CCC_DIRECT_SETMRL)
  ) u_set_mrl (
    .clk_i,
    .rst_ni,
    .data_i    (ccc_data),
    .byte_i    (rx_byte),
    .payload_o (mrl_o),
    .set_o     (set_mrl_o)
  );

  ccc_set_capture #(
    .payload_t (ccc_pkg::event_mask_t),
    .CODE_A    (`CCC_DIRECT_ENEC),
    .CODE_B    (`CCC_DIRECT_ENEC)
  ) u_set_enec (
    .clk_i,
    .rst_ni,
    .data_i    (ccc_data),
    .byte_i    (rx_byte),
    .payload_o (enec_raw),
    .set_o     ()
  );

  ccc_set_capture #(
    .payload_t (ccc_pkg::event_mask_t),
    .CODE_A    (`CCC_DIRECT_DISEC),
    .CODE_B    (`CCC_DIRECT_DISEC)
  ) u_set_disec (
    .clk_i,
    .rst_ni,
    .data_i    (ccc_data),
    .byte_i    (rx_byte),
    .payload_o (disec_raw),
    .set_o     ()
  );

  // Only IBI, CRR and HJ are implemented, reserved bits read zero
  assign enec_o  = '{rsvd_hi: 4'h0, hj: enec_raw.hj, rsvd_lo: 1'b0,
                     crr: enec_raw.crr, ibi: enec_raw.ibi};
  assign disec_o = '{rsvd_hi: 4'h0, hj: disec_raw.hj, rsvd_lo: 1'b0,
                     crr: disec_raw.crr, ibi: disec_raw.ibi};

  ccc_addr_setter u_addr_setter (
    .clk_i,
    .rst_ni,
    .data_i           (ccc_data),
    .byte_i           (rx_byte),
    .tgt_addr_i,
    .set_dasa_o,
    .set_dasa_valid_o,
    .rstdaa_o
  );

endmodule

// ==== sim/ccc_asserts.sv ====
// Concurrent checks on the CCC frame FSM, attached to every ccc_ctrl_fsm by bind
`timescale 1ns/10ps

module ccc_asserts
  import ccc_pkg::*;
(
  input logic     clk_i,
  input logic     rst_ni,
  input bus_req_t bus_req_i,
  input bus_evt_t bus_evt_i,
  input logic     done_i
);

  // Bus engine is either receiving or transmitting
  no_rx_with_tx: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !((bus_req_i.rx_req_bit || bus_req_i.rx_req_byte) &&
      (bus_req_i.tx_req_bit || bus_req_i.tx_req_byte)))
    else $error("receive and transmit requested together");

  done_single_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_i |=> !done_i)
    else $error("done held for more than one cycle");

  // STOP ends the frame on the next cycle
  stop_gives_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_evt_i.stop |=> done_i)
    else $error("no done after STOP");

endmodule

bind ccc_ctrl_fsm ccc_asserts u_asserts (
  .clk_i     (clk_i),
  .rst_ni    (rst_ni),
  .bus_req_i (bus_req_o),
  .bus_evt_i (bus_evt_i),
  .done_i    (done_o)
);

// ==== sim/ccc_tb.sv ====
// Testbench for ccc_top, a bus engine model that replays frames from the vector file
`timescale 1ns/10ps

module ccc_tb
  import ccc_pkg::*;
;

  localparam int TIMEOUT = 200;

  logic        clk;
  logic        rst_n;
  logic [7:0]  ccc;
  logic        ccc_valid;
  bus_evt_t    bus_evt;
  bus_rx_t     bus_rx;
  tgt_addr_t   tgt_addr;
  dev_info_t   dev_info;
  bus_req_t    bus_req;
  logic        done;
  logic        status_done;
  len_t        mwl;
  logic        set_mwl;
  len_t        mrl;
  logic        set_mrl;
  event_mask_t enec;
  event_mask_t disec;
  logic [6:0]  dasa;
  logic        dasa_valid;
  logic        rstdaa;

  integer seed = 32'h3fcc_27d9;
  int     errors = 0;
  int     n_checks = 0;
  // Pulse counters, cleared per frame
  int     n_done;
  int     n_status;
  int     n_mwl;
  int     n_mrl;
  int     n_dasa;
  int     n_rstdaa;
  int     n_tx_cyc;
  logic   done_q;

  ccc_top DUT (
    .clk_i (clk), .rst_ni (rst_n), .ccc_i (ccc), .ccc_valid_i (ccc_valid),
    .bus_evt_i (bus_evt), .bus_rx_i (bus_rx), .tgt_addr_i (tgt_addr),
    .dev_info_i (dev_info), .bus_req_o (bus_req), .done_o (done),
    .get_status_done_o (status_done), .mwl_o (mwl), .set_mwl_o (set_mwl),
    .mrl_o (mrl), .set_mrl_o (set_mrl), .enec_o (enec), .disec_o (disec),
    .set_dasa_o (dasa), .set_dasa_valid_o (dasa_valid), .rstdaa_o (rstdaa)
  );

  always #20 clk = ~clk;

  // Outputs sampled mid-cycle
  always @(negedge clk) begin
    if (rst_n) begin
      if (done) n_done++;
      if (status_done) begin
        n_status++;
        check("status done after done", done_q, 1'b1);
      end
      if (set_mwl) n_mwl++;
      if (set_mrl) n_mrl++;
      if (dasa_valid) n_dasa++;
      if (rstdaa) n_rstdaa++;
      if (bus_req.tx_req_bit || bus_req.tx_req_byte) n_tx_cyc++;
      done_q = done;
    end
  end

  task automatic check(input string what, input logic [47:0] got, input logic [47:0] exp);
    n_checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("Timeout while waiting for the %s", what);
    $display("TEST FAILED");
    $finish;
  endtask

  // 0 rx bit, 1 rx byte, 2 tx bit, 3 tx byte
  task automatic wait_req(input int sel, input string what);
    int   t;
    logic hit;
    t = 0;
    hit = 1'b0;
    while (!hit && t <= TIMEOUT) begin
      @(negedge clk);
      case (sel)
        0: hit = bus_req.rx_req_bit;
        1: hit = bus_req.rx_req_byte;
        2: hit = bus_req.tx_req_bit;
        default: hit = bus_req.tx_req_byte;
      endcase
      t++;
    end
    if (!hit) timeout_fail(what);
  endtask

  task automatic wait_done();
    int t;
    t = 0;
    while (n_done == 0 && t <= TIMEOUT) begin
      @(negedge clk);
      t++;
    end
    if (n_done == 0) timeout_fail("end of frame");
  endtask

  // Engine answers 1 to 4 cycles late
  task automatic engine_delay();
    int d;
    d = 1 + ({$random(seed)} % 4);
    repeat (d) @(posedge clk);
    #2;
  endtask

  task automatic send_rx(input logic [7:0] data);
    engine_delay();
    bus_rx = '{rx_done: 1'b1, tx_done: 1'b0, rx_data: data};
    @(posedge clk);
    #2 bus_rx = '0;
  endtask

  task automatic send_tx();
    engine_delay();
    bus_rx = '{rx_done: 1'b0, tx_done: 1'b1, rx_data: 8'h00};
    @(posedge clk);
    #2 bus_rx = '0;
  endtask

  task automatic send_evt(input logic is_stop);
    engine_delay();
    bus_evt = '{start: 1'b0, rstart: !is_stop, stop: is_stop};
    @(posedge clk);
    #2 bus_evt = '0;
  endtask

  logic [7:0]  kind;
  logic [7:0]  code;
  logic [7:0]  addr;
  logic [7:0]  nb;
  logic [7:0]  chk;
  logic [7:0]  d [6];
  logic [15:0] val;
  len_t        exp_mwl = '0;
  len_t        exp_mrl = '0;
  logic [7:0]  exp_enec = '0;
  logic [7:0]  exp_disec = '0;
  logic [6:0]  exp_dasa = '0;

  task automatic run_frame();
    logic acked;
    logic rsvd;
    n_done = 0;
    n_status = 0;
    n_mwl = 0;
    n_mrl = 0;
    n_dasa = 0;
    n_rstdaa = 0;
    n_tx_cyc = 0;
    rsvd  = (kind != 0) && (addr == 8'hFC);
    acked = (kind == 0) || rsvd || (addr[7:1] == tgt_addr.dyn_addr);
    ccc = code;
    ccc_valid = 1'b1;
    @(posedge clk);
    #2 ccc_valid = 1'b0;
    wait_req(0, "T-bit after the code");
    send_rx(8'h00);
    if (kind != 0) begin
      wait_req(1, "byte before Sr");
      send_evt(1'b0);
      wait_req(1, "direct address");
      send_rx(addr);
      if (acked) begin
        wait_req(2, "address ACK");
        send_tx();
      end
    end
    if (!rsvd && acked && kind == 2) begin
      for (int i = 0; i < nb; i++) begin
        wait_req(3, "reply byte");
        check($sformatf("reply byte %0d of %0h", i, code), bus_req.tx_value, d[i]);
        send_tx();
        wait_req(2, "reply T-bit");
        check("reply T-bit", bus_req.tx_value, (i < nb - 1) ? 8'h01 : 8'h00);
        send_tx();
      end
    end else if (!rsvd && acked) begin
      for (int i = 0; i < nb; i++) begin
        wait_req(1, "data byte");
        send_rx(d[i]);
        wait_req(0, "data T-bit");
        send_rx(8'h00);
      end
    end
    if (!rsvd) send_evt(1'b1);
    wait_done();
    repeat (3) @(negedge clk);
    // Expected register state after this frame
    case (chk)
      1: exp_mwl = val;
      2: exp_mrl = val;
      3: exp_enec = val[7:0] & 8'h0B;
      4: exp_disec = val[7:0] & 8'h0B;
      5: exp_dasa = val[6:0];
      default: ;
    endcase
    check("done pulses", n_done, 1);
    check("GETSTATUS done pulses", n_status, chk == 7);
    check("set_mwl pulses", n_mwl, chk == 1);
    check("set_mrl pulses", n_mrl, chk == 2);
    check("dasa valid pulses", n_dasa, chk == 5);
    check("rstdaa pulses", n_rstdaa, chk == 6);
    check("mwl", mwl, exp_mwl);
    check("mrl", mrl, exp_mrl);
    check("enec", enec, exp_enec);
    check("disec", disec, exp_disec);
    check("set_dasa", dasa, exp_dasa);
    if (!acked) check("tx cycles to foreign address", n_tx_cyc, 0);
  endtask

  initial begin
    int fd;
    int c;
    int r;
    clk = 1'b0;
    rst_n = 1'b0;
    ccc = '0;
    ccc_valid = 1'b0;
    bus_evt = '0;
    bus_rx = '0;
    tgt_addr = '{sta_addr: 7'h2A, sta_valid: 1'b1, dyn_addr: 7'h31, dyn_valid: 1'b1};
    dev_info = '{bcr: 8'h26, dcr: 8'h45, status: 16'h00A5, mwl: 16'h0100,
                 mrl: 16'h0200, pid: 48'h0123_4567_89AB};
    done_q = 1'b0;
    repeat (3) @(posedge clk);
    #2 rst_n = 1'b1;
    fd = $fopen("sim/ccc_vectors.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the vector file sim/ccc_vectors.txt");
      errors++;
    end else begin
      c = $fgetc(fd);
      while (c != -1) begin
        if (c == "#") begin
          while (c != -1 && c != 10) c = $fgetc(fd);
        end else if (c == "v") begin
          r = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h", kind, code, addr, nb,
                      d[0], d[1], d[2], d[3], d[4], d[5], chk, val);
          if (r != 12) begin
            $display("Vector line has %0d fields instead of 12", r);
            errors++;
          end else begin
            repeat (2) @(posedge clk);
            #2 run_frame();
          end
        end
        c = $fgetc(fd);
      end
      $fclose(fd);
    end
    $display("Checks run: %0d, errors: %0d", n_checks, errors);
    if (errors == 0 && n_checks > 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== sim/ccc_vectors.txt ====
# kind (0 broadcast, 1 direct write, 2 direct read), code, address byte, byte count,
# six data or expected reply bytes, check (1 mwl 2 mrl 3 enec 4 disec 5 dasa 6 rstdaa 7 status), value
v 2 8D 63 6 01 23 45 67 89 AB 0 0000
v 2 8E 63 1 26 00 00 00 00 00 0 0000
v 2 8F 63 1 45 00 00 00 00 00 0 0000
v 2 8B 63 2 01 00 00 00 00 00 0 0000
v 2 90 63 2 00 A5 00 00 00 00 7 0000
v 2 8C 63 3 02 00 FF 00 00 00 0 0000
v 0 09 00 2 12 34 00 00 00 00 1 1234
v 1 89 62 2 0A BC 00 00 00 00 1 0ABC
v 0 0A 00 2 00 40 00 00 00 00 2 0040
v 1 8A 62 2 01 80 00 00 00 00 2 0180
v 1 80 62 1 FF 00 00 00 00 00 3 00FF
v 1 81 62 1 F6 00 00 00 00 00 4 00F6
v 1 87 62 1 5A 00 00 00 00 00 5 002D
v 0 29 00 0 00 00 00 00 00 00 5 002A
v 0 06 00 0 00 00 00 00 00 00 6 0000
v 2 8E 41 1 26 00 00 00 00 00 0 0000
v 1 8B FC 0 00 00 00 00 00 00 0 0000
v 0 09 00 0 00 00 00 00 00 00 0 0000

// ==== flist.f ====
+incdir+verilog
verilog/ccc_pkg.sv
verilog/ccc_ctrl_fsm.sv
verilog/ccc_get_responder.sv
verilog/ccc_set_capture.sv
verilog/ccc_addr_setter.sv
verilog/ccc_top.sv
sim/ccc_asserts.sv
sim/ccc_tb.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f flist.f --top-module ccc_tb -Mdir obj_dir
	@out="$$(./obj_dir/Vccc_tb)"; echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir
